//--- list.f
+incdir+design
design/watch_pkg.sv
design/button_sync.sv
design/tick_timebase.sv
design/mode_control.sv
design/clock_watch.sv
design/cook_timer.sv
design/stop_watch.sv
design/display_select.sv
design/multifunction_watch.sv
testbench/tb_multifunction_watch.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_multifunction_watch
FILELIST  = list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- testbench/tb_multifunction_watch.sv
`timescale 1ns/10ps

module tb_multifunction_watch import watch_pkg::*; ();

    // Button codes used by the table
    localparam int BTN_NONE      = 0;
    localparam int BTN_MODE      = 1;
    localparam int BTN_ACT       = 2;
    localparam int BTN_INC_A     = 3;
    localparam int BTN_INC_B     = 4;
    localparam int BTN_ALARM_OFF = 5;

    // What is done with disp_bcd after a row
    localparam int CHK_NONE  = 0;
    localparam int CHK_EXACT = 1;
    localparam int CHK_RANGE = 2;
    localparam int CHK_ALARM = 3;   // Wait field is a limit
    localparam int CHK_SAVE  = 4;
    localparam int CHK_SAME  = 5;

    typedef struct {
        int          button;
        int          count;
        int          wait_cycles;
        int          kind;
        logic [15:0] lo;
        logic [15:0] hi;
        mode_t       exp_mode;
        logic        exp_alarm;
        logic [3:0]  st_mask;
        logic [3:0]  st_exp;
    } step_t;

    logic        clk = 1'b0;
    logic        reset_p;
    logic        mode_btn;
    logic        act_btn;
    logic        inc_a_btn;
    logic        inc_b_btn;
    logic        alarm_off_btn;
    logic [15:0] disp_bcd;
    mode_t       mode;
    logic        alarm;
    status_t     status;

    step_t       steps[$];
    logic        table_ready = 1'b0;
    logic [15:0] saved_disp;
    int          cur_step;
    int          errors;
    int          checks;

    always #20 clk = ~clk;

    multifunction_watch #(.TICK_DIV(4)) u_multifunction_watch (
        .clk(clk), .reset_p(reset_p),
        .mode_btn(mode_btn), .act_btn(act_btn),
        .inc_a_btn(inc_a_btn), .inc_b_btn(inc_b_btn),
        .alarm_off_btn(alarm_off_btn),
        .disp_bcd(disp_bcd), .mode(mode), .alarm(alarm), .status(status)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h (step %0d)", name, got, exp, cur_step);
        end
    endtask

    task automatic drive_button(input int code, input logic level);
        case (code)
            BTN_MODE:      mode_btn      = level;
            BTN_ACT:       act_btn       = level;
            BTN_INC_A:     inc_a_btn     = level;
            BTN_INC_B:     inc_b_btn     = level;
            BTN_ALARM_OFF: alarm_off_btn = level;
            default:       ;
        endcase
    endtask

    // 3 cycles high, 6 low, starting on a falling edge
    task automatic press_button(input int code);
        drive_button(code, 1'b1);
        repeat (3) @(negedge clk);
        drive_button(code, 1'b0);
        repeat (6) @(negedge clk);
    endtask

    task automatic wait_for_alarm(input int limit);
        int waited;
        waited = 0;
        while (alarm !== 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (alarm !== 1'b1) begin
            errors++;
            $display("Step %0d: alarm did not rise within %0d cycles", cur_step, limit);
        end
    endtask

    task automatic add_step(input int button, input int count, input int wait_cycles,
                            input int kind, input logic [15:0] lo, input logic [15:0] hi,
                            input mode_t m, input logic alm,
                            input logic [3:0] mask, input logic [3:0] st);
        steps.push_back(step_t'{button, count, wait_cycles, kind, lo, hi, m, alm, mask, st});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    // Status mask bits are set_watch, cook_running, sw_running and lap_view
    task automatic build_table();
        add_step(BTN_NONE,  0,  2, CHK_EXACT, 16'h0000, 16'h0, WATCH, 1'b0, 4'hF, 4'h0);
        // 61 seconds presses in set mode wrap to 01
        add_step(BTN_ACT,   1,  0, CHK_EXACT, 16'h0000, 16'h0, WATCH, 1'b0, 4'h8, 4'h8);
        add_step(BTN_INC_A, 61, 0, CHK_EXACT, 16'h0001, 16'h0, WATCH, 1'b0, 4'h8, 4'h8);
        add_step(BTN_INC_B, 3,  0, CHK_EXACT, 16'h0301, 16'h0, WATCH, 1'b0, 4'h8, 4'h8);
        // Stopwatch buttons must not reach the clock
        add_step(BTN_MODE,  1,  0, CHK_EXACT, 16'h0000, 16'h0, COOK_TIMER, 1'b0, 4'h0, 4'h0);
        add_step(BTN_MODE,  1,  0, CHK_EXACT, 16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h0, 4'h0);
        add_step(BTN_ACT,   1,  0, CHK_NONE,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'hF, 4'hA);
        add_step(BTN_ACT,   1,  0, CHK_NONE,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'hF, 4'h8);
        add_step(BTN_INC_B, 1,  0, CHK_EXACT, 16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'hF, 4'h8);
        add_step(BTN_MODE,  1,  0, CHK_EXACT, 16'h0301, 16'h0, WATCH, 1'b0, 4'h8, 4'h8);
        // About 800 cycles of running time gives one or two seconds
        add_step(BTN_ACT, 1, 780, CHK_RANGE, 16'h0302, 16'h0303, WATCH, 1'b0, 4'h8, 4'h0);
        // Cook timer set to 0 min 2 s
        add_step(BTN_MODE,  1,  0, CHK_EXACT, 16'h0000, 16'h0, COOK_TIMER, 1'b0, 4'h4, 4'h0);
        add_step(BTN_INC_A, 2,  0, CHK_EXACT, 16'h0002, 16'h0, COOK_TIMER, 1'b0, 4'h4, 4'h0);
        add_step(BTN_ACT,   1,  0, CHK_NONE,  16'h0000, 16'h0, COOK_TIMER, 1'b0, 4'h4, 4'h4);
        add_step(BTN_NONE, 0, 1300, CHK_ALARM, 16'h0000, 16'h0, COOK_TIMER, 1'b1, 4'h4, 4'h0);
        add_step(BTN_ALARM_OFF, 1, 0, CHK_EXACT, 16'h0002, 16'h0, COOK_TIMER, 1'b0, 4'h4, 4'h0);
        // 200 cycles from act to act is 50 csec
        add_step(BTN_MODE,  1,  0, CHK_EXACT, 16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h3, 4'h0);
        add_step(BTN_ACT, 1, 191, CHK_NONE,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h2, 4'h2);
        add_step(BTN_ACT, 1, 0, CHK_RANGE, 16'h0048, 16'h0051, STOP_WATCH, 1'b0, 4'h2, 4'h0);
        // Lap freeze followed by stop and clear
        add_step(BTN_ACT,   1,  0, CHK_NONE,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h2, 4'h2);
        add_step(BTN_INC_A, 1,  0, CHK_SAVE,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h3, 4'h3);
        add_step(BTN_NONE, 0, 200, CHK_SAME,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h3, 4'h3);
        add_step(BTN_ACT,   1,  0, CHK_SAME,  16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h3, 4'h1);
        add_step(BTN_INC_B, 1,  0, CHK_EXACT, 16'h0000, 16'h0, STOP_WATCH, 1'b0, 4'h3, 4'h0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        step_t step;
        reset_p       = 1'b1;
        mode_btn      = 1'b0;
        act_btn       = 1'b0;
        inc_a_btn     = 1'b0;
        inc_b_btn     = 1'b0;
        alarm_off_btn = 1'b0;
        errors        = 0;
        checks        = 0;
        cur_step      = 0;
        saved_disp    = '0;
        build_table();
        table_ready = 1'b1;

        repeat (8) @(negedge clk);
        reset_p = 1'b0;

        foreach (steps[i]) begin
            step     = steps[i];
            cur_step = i;
            repeat (step.count) press_button(step.button);
            if (step.kind == CHK_ALARM)
                wait_for_alarm(step.wait_cycles);
            else
                repeat (step.wait_cycles) @(negedge clk);

            case (step.kind)
                CHK_EXACT, CHK_ALARM: check_value("disp_bcd", disp_bcd, step.lo);
                CHK_SAME:             check_value("disp_bcd", disp_bcd, saved_disp);
                CHK_SAVE:             saved_disp = disp_bcd;
                CHK_RANGE: begin
                    checks++;
                    if ($isunknown(disp_bcd) || disp_bcd < step.lo || disp_bcd > step.hi) begin
                        errors++;
                        $display("FAILED disp_bcd: got 0x%h, expected 0x%h to 0x%h (step %0d)",
                                 disp_bcd, step.lo, step.hi, cur_step);
                    end
                end
                default: ;
            endcase
            check_value("mode", 16'(mode), 16'(step.exp_mode));
            check_value("alarm", 16'(alarm), 16'(step.exp_alarm));
            check_value("status", 16'(status & step.st_mask), 16'(step.st_exp & step.st_mask));
        end

        $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Limit from the table's presses and waits plus reset and margin
    initial begin
        int limit;
        wait (table_ready);
        limit = 2000 + 8;
        foreach (steps[i])
            limit += steps[i].wait_cycles + 9 * steps[i].count;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- design/multifunction_watch.sv
`timescale 1ns/10ps
`include "watch_defs.svh"

module multifunction_watch import watch_pkg::*; #(
    parameter int TICK_DIV = `TICK_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        reset_p,
    input  logic        mode_btn,
    input  logic        act_btn,
    input  logic        inc_a_btn,
    input  logic        inc_b_btn,
    input  logic        alarm_off_btn,
    output logic [15:0] disp_bcd,
    output mode_t       mode,
    output logic        alarm,
    output status_t     status
);

    btn_pulse_t pulses;
    logic       csec_tick;
    logic       sec_tick;
    func_btn_t  watch_btn;
    func_btn_t  cook_btn;
    func_btn_t  sw_btn;
    logic       alarm_off;
    time_pair_t watch_time;
    time_pair_t cook_time;
    time_pair_t sw_time;
    logic       set_watch;
    logic       cook_running;
    logic       sw_running;
    logic       lap_view;

    ////////////////////////////////////////////////////////////////////////////
    // Inputs, timebase and mode
    ////////////////////////////////////////////////////////////////////////////

    button_sync u_button_sync (
        .clk(clk), .reset_p(reset_p),
        .mode_btn(mode_btn), .act_btn(act_btn),
        .inc_a_btn(inc_a_btn), .inc_b_btn(inc_b_btn),
        .alarm_off_btn(alarm_off_btn),
        .pulses(pulses)
    );

    tick_timebase #(.TICK_DIV(TICK_DIV)) u_tick_timebase (
        .clk(clk), .reset_p(reset_p),
        .csec_tick(csec_tick), .sec_tick(sec_tick)
    );

    mode_control u_mode_control (
        .clk(clk), .reset_p(reset_p), .pulses(pulses), .mode(mode),
        .watch_btn(watch_btn), .cook_btn(cook_btn), .sw_btn(sw_btn),
        .alarm_off(alarm_off)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Functions and display
    ////////////////////////////////////////////////////////////////////////////

    clock_watch u_clock_watch (
        .clk(clk), .reset_p(reset_p), .btns(watch_btn), .sec_tick(sec_tick),
        .now(watch_time), .set_watch(set_watch)
    );

    cook_timer u_cook_timer (
        .clk(clk), .reset_p(reset_p), .btns(cook_btn), .alarm_off(alarm_off),
        .sec_tick(sec_tick), .remain(cook_time), .running(cook_running),
        .alarm(alarm)
    );

    stop_watch u_stop_watch (
        .clk(clk), .reset_p(reset_p), .btns(sw_btn), .csec_tick(csec_tick),
        .shown(sw_time), .running(sw_running), .lap_view(lap_view)
    );

    display_select u_display_select (
        .clk(clk), .reset_p(reset_p), .mode(mode),
        .watch_time(watch_time), .cook_time(cook_time), .sw_time(sw_time),
        .disp_bcd(disp_bcd)
    );

    assign status = '{
        set_watch:    set_watch,
        cook_running: cook_running,
        sw_running:   sw_running,
        lap_view:     lap_view
    };

endmodule

//--- design/display_select.sv
`timescale 1ns/10ps

module display_select import watch_pkg::*; (
    input  logic        clk,
    input  logic        reset_p,
    input  mode_t       mode,
    input  time_pair_t  watch_time,
    input  time_pair_t  cook_time,
    input  time_pair_t  sw_time,
    output logic [15:0] disp_bcd
);

    disp_pair_u sel;
    time_byte_t hi_bin;
    time_byte_t lo_bin;

    // Inputs never exceed 99
    function automatic logic [7:0] to_bcd(input time_byte_t bin);
        time_byte_t tens;
        time_byte_t ones;
        tens = bin / 8'd10;
        ones = bin - tens * 8'd10;
        return {tens[3:0], ones[3:0]};
    endfunction

    always_comb begin
        case (mode)
            COOK_TIMER: sel.pair = cook_time;
            STOP_WATCH: sel.pair = sw_time;
            default:    sel.pair = watch_time;
        endcase
    end

    // Min/sec or sec/csec share the same byte positions
    assign hi_bin = sel.pair.high;
    assign lo_bin = sel.pair.low;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p)
            disp_bcd <= '0;
        else
            disp_bcd <= {to_bcd(hi_bin), to_bcd(lo_bin)};
    end

endmodule

//--- design/stop_watch.sv
`timescale 1ns/10ps
`include "watch_defs.svh"

module stop_watch import watch_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  func_btn_t  btns,
    input  logic       csec_tick,
    output time_pair_t shown,
    output logic       running,
    output logic       lap_view
);

    time_byte_t sec;
    time_byte_t csec;
    time_byte_t lap_sec;
    time_byte_t lap_csec;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running  <= 1'b0;
            lap_view <= 1'b0;
            sec      <= '0;
            csec     <= '0;
            lap_sec  <= '0;
            lap_csec <= '0;
        end else if (btns.inc_b) begin
            // Clear leaves run state alone
            lap_view <= 1'b0;
            sec      <= '0;
            csec     <= '0;
            lap_sec  <= '0;
            lap_csec <= '0;
        end else begin
            if (btns.act)
                running <= ~running;

            if (btns.inc_a) begin
                lap_view <= ~lap_view;
                if (!lap_view) begin
                    lap_sec  <= sec;   // Capture on entry
                    lap_csec <= csec;
                end
            end

            if (running && csec_tick) begin
                if (csec >= `CSEC_MAX) begin
                    csec <= '0;
                    sec  <= (sec >= `WATCH_SEC_MAX) ? '0 : sec + 8'd1;
                end else begin
                    csec <= csec + 8'd1;
                end
            end
        end
    end

    assign shown = lap_view ? time_pair_t'{high: lap_sec, low: lap_csec}
                            : time_pair_t'{high: sec, low: csec};

endmodule

//--- design/cook_timer.sv
`timescale 1ns/10ps
`include "watch_defs.svh"

module cook_timer import watch_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  func_btn_t  btns,
    input  logic       alarm_off,
    input  logic       sec_tick,
    output time_pair_t remain,
    output logic       running,
    output logic       alarm
);

    time_byte_t sec;
    time_byte_t min;
    time_byte_t preset_sec;
    time_byte_t preset_min;
    logic       at_zero;
    logic       start;
    logic       any_clear;

    assign at_zero   = (sec == '0) && (min == '0);
    assign start     = !running && !alarm && btns.act && !at_zero;
    assign any_clear = alarm_off | btns.act | btns.inc_a | btns.inc_b;

    always_ff @(posedge clk) begin
        if (start) begin
            preset_sec <= sec;   // Restored after the alarm
            preset_min <= min;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Edit, count-down and alarm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
            alarm   <= 1'b0;
            sec     <= '0;
            min     <= '0;
        end else if (alarm) begin
            if (any_clear) begin
                alarm <= 1'b0;
                sec   <= preset_sec;
                min   <= preset_min;
            end
        end else if (running) begin
            if (btns.act) begin
                running <= 1'b0;   // Pause
            end else if (at_zero) begin
                running <= 1'b0;
                alarm   <= 1'b1;
            end else if (sec_tick) begin
                if (sec == '0) begin
                    sec <= `WATCH_SEC_MAX;   // Borrow a minute
                    min <= min - 8'd1;
                end else begin
                    sec <= sec - 8'd1;
                end
            end
        end else begin
            if (start)
                running <= 1'b1;
            if (btns.inc_a)
                sec <= (sec >= `WATCH_SEC_MAX) ? '0 : sec + 8'd1;
            if (btns.inc_b)
                min <= (min >= `COOK_MIN_MAX) ? '0 : min + 8'd1;
        end
    end

    assign remain = '{high: min, low: sec};

endmodule

//--- design/clock_watch.sv
`timescale 1ns/10ps
`include "watch_defs.svh"

module clock_watch import watch_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  func_btn_t  btns,
    input  logic       sec_tick,
    output time_pair_t now,
    output logic       set_watch
);

    time_byte_t sec;
    time_byte_t min;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_watch <= 1'b0;
            sec       <= '0;
            min       <= '0;
        end else begin
            if (btns.act)
                set_watch <= ~set_watch;

            if (set_watch) begin
                // Manual adjust, time frozen
                if (btns.inc_a)
                    sec <= (sec >= `WATCH_SEC_MAX) ? '0 : sec + 8'd1;
                if (btns.inc_b)
                    min <= (min >= `WATCH_MIN_MAX) ? '0 : min + 8'd1;
            end else if (sec_tick) begin
                if (sec >= `WATCH_SEC_MAX) begin
                    sec <= '0;
                    min <= (min >= `WATCH_MIN_MAX) ? '0 : min + 8'd1;
                end else begin
                    sec <= sec + 8'd1;
                end
            end
        end
    end

    assign now = '{high: min, low: sec};

endmodule

//--- design/mode_control.sv
`timescale 1ns/10ps

module mode_control import watch_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  btn_pulse_t pulses,
    output mode_t      mode,
    output func_btn_t  watch_btn,
    output func_btn_t  cook_btn,
    output func_btn_t  sw_btn,
    output logic       alarm_off
);

    func_btn_t fn_pulse;

    assign fn_pulse  = '{act: pulses.act, inc_a: pulses.inc_a, inc_b: pulses.inc_b};
    assign alarm_off = pulses.alarm_off;   // Alarm can be silenced from any mode

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= WATCH;
        end else if (pulses.mode) begin
            case (mode)
                WATCH:      mode <= COOK_TIMER;
                COOK_TIMER: mode <= STOP_WATCH;
                default:    mode <= WATCH;
            endcase
        end
    end

    // Only the active function sees the buttons
    always_comb begin
        watch_btn = '0;
        cook_btn  = '0;
        sw_btn    = '0;
        case (mode)
            WATCH:      watch_btn = fn_pulse;
            COOK_TIMER: cook_btn  = fn_pulse;
            STOP_WATCH: sw_btn    = fn_pulse;
            default:    watch_btn = '0;   // Unused encoding
        endcase
    end

endmodule

//--- design/tick_timebase.sv
`timescale 1ns/10ps
`include "watch_defs.svh"

module tick_timebase import watch_pkg::*; #(
    parameter int TICK_DIV = `TICK_DIV_DEFAULT
) (
    input  logic clk,
    input  logic reset_p,
    output logic csec_tick,
    output logic sec_tick
);

    localparam int DIV_W = $clog2(TICK_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    time_byte_t       csec_cnt;

    assign csec_tick = (div_cnt == DIV_LAST);
    assign sec_tick  = csec_tick && (csec_cnt == `CSEC_MAX);   // Every 100th csec

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt  <= '0;
            csec_cnt <= '0;
        end else if (csec_tick) begin
            div_cnt <= '0;
            if (sec_tick)
                csec_cnt <= '0;
            else
                csec_cnt <= csec_cnt + 8'd1;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

endmodule

//--- design/button_sync.sv
`timescale 1ns/10ps

module button_sync import watch_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  logic       mode_btn,
    input  logic       act_btn,
    input  logic       inc_a_btn,
    input  logic       inc_b_btn,
    input  logic       alarm_off_btn,
    output btn_pulse_t pulses
);

    btn_pulse_t raw;
    btn_pulse_t sync_1;
    btn_pulse_t sync_2;
    btn_pulse_t prev;

    assign raw = '{
        mode:      mode_btn,
        act:       act_btn,
        inc_a:     inc_a_btn,
        inc_b:     inc_b_btn,
        alarm_off: alarm_off_btn
    };

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_1 <= '0;
            sync_2 <= '0;
            prev   <= '0;
        end else begin
            sync_1 <= raw;     // Two-stage synchronizer
            sync_2 <= sync_1;
            prev   <= sync_2;
        end
    end

    assign pulses = sync_2 & ~prev;   // Rising edges only

endmodule

//--- design/watch_pkg.sv
package watch_pkg;

    typedef enum logic [1:0] {
        WATCH      = 2'd0,
        COOK_TIMER = 2'd1,
        STOP_WATCH = 2'd2
    } mode_t;

    typedef logic [7:0] time_byte_t;

    // One-cycle pulses from the buttons
    typedef struct packed {
        logic mode;
        logic act;
        logic inc_a;
        logic inc_b;
        logic alarm_off;
    } btn_pulse_t;

    typedef struct packed {
        logic act;
        logic inc_a;
        logic inc_b;
    } func_btn_t;

    typedef struct packed {
        time_byte_t high;
        time_byte_t low;
    } time_pair_t;

    typedef struct packed {
        time_byte_t min;
        time_byte_t sec;
    } clock_view_t;

    typedef struct packed {
        time_byte_t sec;
        time_byte_t csec;
    } sw_view_t;

    // Same display word read as min/sec or sec/csec
    typedef union packed {
        time_pair_t  pair;
        clock_view_t clk_view;
        sw_view_t    sw_view;
    } disp_pair_u;

    typedef struct packed {
        logic set_watch;
        logic cook_running;
        logic sw_running;
        logic lap_view;
    } status_t;

endpackage

//--- design/watch_defs.svh
`ifndef WATCH_DEFS_SVH
`define WATCH_DEFS_SVH

// Last value before wrap in binary
`define WATCH_SEC_MAX 8'd59
`define WATCH_MIN_MAX 8'd59
`define COOK_MIN_MAX 8'd99

// Centiseconds per second minus one
`define CSEC_MAX 8'd99

// 100 MHz clock
`define TICK_DIV_DEFAULT 1_000_000

`endif
